//--- sources.f
+incdir+source
+incdir+tests
source/xbar_pkg.sv
source/tcam_block.sv
source/lane_decode.sv
source/route_execute.sv
source/match_result.sv
source/segment_crossbar.sv
tests/tb_segment_crossbar.sv

//--- tests/tb_model.svh
// Reference model of the two logical tables
// Shadow entries per table and the expected response of a search
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [31:0] shadow_value [`XB_NUM_LMTS][`XB_LMT_DEPTH];
logic [31:0] shadow_care  [`XB_NUM_LMTS][`XB_LMT_DEPTH];
logic        shadow_valid [`XB_NUM_LMTS][`XB_LMT_DEPTH];

task automatic model_clear();
    for (int t = 0; t < `XB_NUM_LMTS; t++) begin
        for (int e = 0; e < `XB_LMT_DEPTH; e++) begin
            shadow_valid[t][e] = 1'b0;
        end
    end
endtask

task automatic model_write(input int t, input int a, input [31:0] d, input [31:0] c);
    shadow_value[t][a] = d;
    shadow_care[t][a]  = c;
    shadow_valid[t][a] = 1'b1;
endtask

// Entry hits when every cared bit inside the table width equals the key
function automatic logic [31:0] model_matchlines(input int t, input [31:0] key);
    logic [31:0] ml;
    logic [31:0] wmask;
    int          depth;
    ml    = '0;
    wmask = cfg[t].width_gear ? 32'hFFFF_FFFF : 32'h0000_FFFF;
    depth = 8 << cfg[t].depth_gear;
    for (int e = 0; e < depth; e++) begin
        ml[e] = shadow_valid[t][e] &&
                (((shadow_value[t][e] ^ key) & shadow_care[t][e] & wmask) == '0);
    end
    return ml;
endfunction

function automatic xbar_pkg::xbar_resp_t model_response(input int t, input [31:0] key);
    xbar_pkg::xbar_resp_t r;
    r            = '0;
    r.lmt        = t[0];
    r.matchlines = model_matchlines(t, key);
    r.found      = |r.matchlines;
    for (int e = `XB_LMT_DEPTH - 1; e >= 0; e--) begin
        if (r.matchlines[e]) begin
            r.match_addr = e[4:0];
        end
    end
    return r;
endfunction

`endif

//--- tests/tb_segment_crossbar.sv
// Segment crossbar testbench
// Runs a table of writes and searches through the request port, checks every
// response in order against the reference model under random back-pressure
`timescale 1ns/1ns
`default_nettype none

`include "xbar_consts.svh"

module tb_segment_crossbar;

    typedef struct packed {
        xbar_pkg::req_op_t op;
        logic              lmt;
        logic [4:0]        addr;
        logic [31:0]       data;
        logic [31:0]       care;
        logic              exp_found;
        logic [4:0]        exp_addr;
    } step_t;

    logic                                  clk;
    logic                                  rst_n;
    xbar_pkg::lmt_cfg_t [`XB_NUM_LMTS-1:0] cfg;
    xbar_pkg::xbar_req_t                   req;
    logic                                  req_valid;
    logic                                  req_ready;
    xbar_pkg::xbar_resp_t                  resp;
    logic                                  resp_valid;
    logic                                  resp_ready;

    step_t                step_q[$];
    xbar_pkg::xbar_resp_t expect_q[$];
    logic [31:0]          lfsr_state;
    int                   cycle_count;
    logic                 stall_seen;
    xbar_pkg::xbar_resp_t stall_resp;

    `include "tb_model.svh"

    segment_crossbar dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready)
    );

    always #5 clk = ~clk;

    // ========================================
    // Helpers
    // ========================================
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic add_write(input logic t, input [4:0] a, input [31:0] d, input [31:0] c);
        step_q.push_back('{xbar_pkg::REQ_WRITE, t, a, d, c, 1'b0, 5'd0});
    endtask

    task automatic add_search(input logic t, input [31:0] key, input logic f, input [4:0] a);
        step_q.push_back('{xbar_pkg::REQ_SEARCH, t, 5'd0, key, 32'd0, f, a});
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic xbar_pkg::xbar_req_t build_req(input step_t s);
        xbar_pkg::xbar_req_t r;
        r     = '0;
        r.op  = s.op;
        r.lmt = s.lmt;
        if (s.op == xbar_pkg::REQ_WRITE) begin
            r.addr            = s.addr;
            r.payload.wr.data = s.data;
            r.payload.wr.care = s.care;
        end else begin
            r.payload.srch.key = s.data;
        end
        return r;
    endfunction

    // Model update or expected response, at the edge where the request transfers
    task automatic accept_step(input step_t s);
        xbar_pkg::xbar_resp_t exp;
        if (s.op == xbar_pkg::REQ_WRITE) begin
            model_write(s.lmt, s.addr, s.data, s.care);
        end else begin
            exp = model_response(s.lmt, s.data);
            assert (exp.found == s.exp_found && (!s.exp_found || exp.match_addr == s.exp_addr))
            else stop_run($sformatf("FAIL at %0t ns: model gives found=%0d addr=%0d for key %h",
                                    $time, exp.found, exp.match_addr, s.data));
            expect_q.push_back(exp);
        end
    endtask

    // ========================================
    // Back-pressure and response monitor
    // ========================================
    always @(posedge clk) begin
        if (rst_n) begin
            resp_ready <= lfsr_state[0];
            lfsr_state <= lfsr_next(lfsr_state);
        end
    end

    always @(posedge clk) begin
        xbar_pkg::xbar_resp_t exp;
        if (rst_n) begin
            if (stall_seen) begin
                assert (resp_valid && resp == stall_resp)
                else stop_run($sformatf("FAIL at %0t ns: response changed while stalled", $time));
            end
            stall_seen = resp_valid && !resp_ready;
            stall_resp = resp;
            if (resp_valid && resp_ready) begin
                if (expect_q.size() == 0) begin
                    stop_run("Response arrived with no search outstanding");
                end else begin
                    exp = expect_q.pop_front();
                    assert (resp == exp)
                    else stop_run($sformatf(
                        "FAIL at %0t ns: resp lmt=%0d found=%0d addr=%0d ml=%h, expected %0d %0d %0d %h",
                        $time, resp.lmt, resp.found, resp.match_addr, resp.matchlines,
                        exp.lmt, exp.found, exp.match_addr, exp.matchlines));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= 20 * step_q.size() + 100) begin
            stop_run($sformatf("Timeout: run did not finish within %0d cycles", cycle_count));
        end
    end

    // ========================================
    // Stimulus
    // ========================================
    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        req          = '0;
        req_valid    = 1'b0;
        resp_ready   = 1'b0;
        lfsr_state   = 32'd69693;
        cycle_count  = 0;
        stall_seen   = 1'b0;
        // Table 0 is 32 bits x 8, table 1 is 16 bits x 32
        cfg[0] = '{first_pmt: 3'd0, pmt_count: 4'd2, width_gear: 1'b1, depth_gear: 2'd0};
        cfg[1] = '{first_pmt: 3'd2, pmt_count: 4'd4, width_gear: 1'b0, depth_gear: 2'd2};
        model_clear();

        // Two-wide match, upper or lower segment mismatch
        add_write(0, 5'd2, 32'hCAFE_1234, 32'hFFFF_FFFF);
        add_search(0, 32'hCAFE_1234, 1'b1, 5'd2);
        add_search(0, 32'hBEEF_1234, 1'b0, 5'd0);
        add_search(0, 32'hCAFE_1235, 1'b0, 5'd0);
        // Depth rows of table 1, upper key half ignored
        add_write(1, 5'd3, 32'h0000_5A5A, 32'h0000_FFFF);
        add_write(1, 5'd27, 32'h0000_A5A5, 32'h0000_FFFF);
        add_search(1, 32'h1234_5A5A, 1'b1, 5'd3);
        add_search(1, 32'h0000_A5A5, 1'b1, 5'd27);
        // Don't-care low byte, then overwrite
        add_write(1, 5'd12, 32'h0000_3C00, 32'h0000_FF00);
        add_search(1, 32'h0000_3C7E, 1'b1, 5'd12);
        add_search(1, 32'h0000_3D00, 1'b0, 5'd0);
        add_write(1, 5'd12, 32'h0000_7777, 32'h0000_FFFF);
        add_search(1, 32'h0000_3C7E, 1'b0, 5'd0);
        add_search(1, 32'h0000_7777, 1'b1, 5'd12);
        // Priority and table independence
        add_write(1, 5'd20, 32'h0000_0000, 32'h0000_0000);
        add_search(1, 32'h0000_A5A5, 1'b1, 5'd20);
        add_search(1, 32'h0000_5A5A, 1'b1, 5'd3);
        add_write(0, 5'd5, 32'h0000_0000, 32'h0000_0000);
        add_write(0, 5'd6, 32'hCAFE_1234, 32'hFFFF_FFFF);
        add_search(0, 32'hCAFE_1234, 1'b1, 5'd2);
        add_search(0, 32'h0000_7777, 1'b1, 5'd5);
        add_write(0, 5'd1, 32'hFFFF_0000, 32'hFFFF_0000);
        add_search(0, 32'hFFFF_1111, 1'b1, 5'd1);
        add_search(1, 32'h0000_1111, 1'b1, 5'd20);
        // Back-to-back burst
        add_search(0, 32'hCAFE_1235, 1'b1, 5'd5);
        add_search(1, 32'h0000_3C7E, 1'b1, 5'd20);
        add_search(1, 32'h0000_7777, 1'b1, 5'd12);
        add_search(0, 32'hFFFF_0000, 1'b1, 5'd1);

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (!resp_valid && req_ready)
        else stop_run($sformatf("FAIL at %0t ns: resp_valid=%0d req_ready=%0d after reset",
                                $time, resp_valid, req_ready));

        for (int i = 0; i < step_q.size(); i++) begin
            req       <= build_req(step_q[i]);
            req_valid <= 1'b1;
            @(posedge clk);
            while (!req_ready) begin
                @(posedge clk);
            end
            accept_step(step_q[i]);
        end
        req_valid <= 1'b0;

        while (expect_q.size() != 0) begin
            @(posedge clk);
        end
        // Quiet period, no further response may show up
        repeat (8) @(posedge clk);
        assert (!resp_valid)
        else stop_run($sformatf("FAIL at %0t ns: response valid with no search outstanding",
                                $time));
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/segment_crossbar.sv
// Segment crossbar top level
// Request port feeds decode, the command register and eight TCAM blocks;
// their matchlines are merged into one response per search
`timescale 1ns/1ns
`default_nettype none

`include "xbar_consts.svh"

module segment_crossbar (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  xbar_pkg::lmt_cfg_t [`XB_NUM_LMTS-1:0]  cfg,
    input  xbar_pkg::xbar_req_t                    req,
    input  logic                                   req_valid,
    output logic                                   req_ready,
    output xbar_pkg::xbar_resp_t                   resp,
    output logic                                   resp_valid,
    input  logic                                   resp_ready
);

    logic                                       advance;
    logic                                       req_fire;
    xbar_pkg::lane_cmd_t [`XB_NUM_PMTS-1:0]     dec_lanes;
    xbar_pkg::srch_tag_t                        dec_tag;
    xbar_pkg::lane_cmd_t [`XB_NUM_PMTS-1:0]     exe_lanes;
    xbar_pkg::srch_tag_t                        exe_tag;
    logic [`XB_NUM_PMTS-1:0][`XB_PMT_DEPTH-1:0] pmt_ml;

    assign req_ready = advance;
    assign req_fire  = req_valid && advance;

    // ========================================
    // Decode
    // ========================================
    lane_decode u_decode (
        .req      (req),
        .req_fire (req_fire),
        .cfg      (cfg),
        .lanes    (dec_lanes),
        .tag      (dec_tag)
    );

    // ========================================
    // Execute
    // ========================================
    route_execute u_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .advance  (advance),
        .lanes_in (dec_lanes),
        .tag_in   (dec_tag),
        .lanes    (exe_lanes),
        .tag      (exe_tag)
    );

    for (genvar b = 0; b < `XB_NUM_PMTS; b++) begin : g_pmt
        tcam_block u_pmt (
            .clk       (clk),
            .rst_n     (rst_n),
            .advance   (advance),
            .cmd       (exe_lanes[b]),
            .matchline (pmt_ml[b])
        );
    end

    // ========================================
    // Result
    // ========================================
    match_result u_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .matchlines (pmt_ml),
        .tag_in     (exe_tag),
        .resp_ready (resp_ready),
        .advance    (advance),
        .resp       (resp),
        .resp_valid (resp_valid)
    );

endmodule

`default_nettype wire

//--- source/match_result.sv
// Segment crossbar result stage
// Mask-ANDs block matchlines across each row, combines the rows into one
// logical matchline, picks the lowest hit and registers the response
`timescale 1ns/1ns
`default_nettype none

`include "xbar_consts.svh"

module match_result (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic [`XB_NUM_PMTS-1:0][`XB_PMT_DEPTH-1:0] matchlines,
    input  xbar_pkg::srch_tag_t                        tag_in,
    input  logic                                       resp_ready,
    output logic                                       advance,
    output xbar_pkg::xbar_resp_t                       resp,
    output logic                                       resp_valid
);

    localparam int ID_W   = `XB_PMT_ID_W;
    localparam int ADDR_W = `XB_LMT_ADDR_W;

    xbar_pkg::srch_tag_t                         tag_q;
    logic                                        tag_valid_q;
    logic [`XB_MAX_ROWS-1:0][`XB_PMT_DEPTH-1:0]  row_ml;
    logic [`XB_LMT_DEPTH-1:0]                    lmt_ml;
    logic                                        found;
    logic [ADDR_W-1:0]                           first_hit;
    xbar_pkg::xbar_resp_t                        resp_q;
    logic                                        resp_valid_q;

    // Whole pipeline stalls only on a held response
    assign advance = !(resp_valid_q && !resp_ready);

    // ========================================
    // Tag copy aligned with block matchlines
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_valid_q <= 1'b0;
        end else if (advance) begin
            tag_valid_q <= tag_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            tag_q <= tag_in;
        end
    end

    // ========================================
    // Mask-AND and combine
    // ========================================
    always_comb begin
        logic [ID_W-1:0]      rel;
        logic [`XB_ROW_W-1:0] row;
        row_ml = '1;
        for (int b = 0; b < `XB_NUM_PMTS; b++) begin
            rel = ID_W'(b) - tag_q.first_pmt;
            row = tag_q.width_gear ? rel[`XB_ROW_W:1] : rel[`XB_ROW_W-1:0];
            if (tag_q.member[b]) begin
                row_ml[row] = row_ml[row] & matchlines[b];
            end
        end
        // Rows past the table depth hold no entries
        for (int r = 0; r < `XB_MAX_ROWS; r++) begin
            lmt_ml[r*`XB_PMT_DEPTH +: `XB_PMT_DEPTH] =
                (r < (1 << tag_q.depth_gear)) ? row_ml[r] : '0;
        end
    end

    // Lowest index wins
    always_comb begin
        found     = |lmt_ml;
        first_hit = '0;
        for (int e = `XB_LMT_DEPTH - 1; e >= 0; e--) begin
            if (lmt_ml[e]) begin
                first_hit = ADDR_W'(e);
            end
        end
    end

    // ========================================
    // Response register
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid_q <= 1'b0;
        end else if (advance) begin
            resp_valid_q <= tag_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            resp_q.lmt        <= tag_q.lmt;
            resp_q.found      <= found;
            resp_q.match_addr <= first_hit;
            resp_q.matchlines <= lmt_ml;
        end
    end

    assign resp       = resp_q;
    assign resp_valid = resp_valid_q;

    resp_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        resp_valid_q && !resp_ready |=> resp_valid_q && $stable(resp_q)
    ) else $error("response changed while stalled");

endmodule

`default_nettype wire

//--- source/route_execute.sv
// Segment crossbar command pipeline register
// Holds the lane commands and the search tag between decode and the blocks,
// loading on advance and holding while the response port is stalled
`timescale 1ns/1ns
`default_nettype none

`include "xbar_consts.svh"

module route_execute (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   advance,
    input  xbar_pkg::lane_cmd_t [`XB_NUM_PMTS-1:0] lanes_in,
    input  xbar_pkg::srch_tag_t                    tag_in,
    output xbar_pkg::lane_cmd_t [`XB_NUM_PMTS-1:0] lanes,
    output xbar_pkg::srch_tag_t                    tag
);

    // ========================================
    // Control state
    // ========================================
    logic [`XB_NUM_PMTS-1:0] wr_en_q;
    logic [`XB_NUM_PMTS-1:0] srch_en_q;
    logic                    tag_valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en_q     <= '0;
            srch_en_q   <= '0;
            tag_valid_q <= 1'b0;
        end else if (advance) begin
            for (int b = 0; b < `XB_NUM_PMTS; b++) begin
                wr_en_q[b]   <= lanes_in[b].wr_en;
                srch_en_q[b] <= lanes_in[b].srch_en;
            end
            tag_valid_q <= tag_in.valid;
        end
    end

    // ========================================
    // Payload
    // ========================================
    xbar_pkg::lane_cmd_t [`XB_NUM_PMTS-1:0] lane_q;
    xbar_pkg::srch_tag_t                    tag_q;

    always_ff @(posedge clk) begin
        if (advance) begin
            lane_q <= lanes_in;
            tag_q  <= tag_in;
        end
    end

    // Enables and valid come from the reset copies
    always_comb begin
        for (int b = 0; b < `XB_NUM_PMTS; b++) begin
            lanes[b]         = lane_q[b];
            lanes[b].wr_en   = wr_en_q[b];
            lanes[b].srch_en = srch_en_q[b];
        end
        tag       = tag_q;
        tag.valid = tag_valid_q;
    end

    // A block never gets a write and a search in the same slot
    lane_op_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr_en_q & srch_en_q) == '0
    ) else $error("lane with write and search enabled together");

    // A search tag always comes with at least one searching block
    tag_has_lanes: assert property (
        @(posedge clk) disable iff (!rst_n)
        tag_valid_q |-> (|srch_en_q)
    ) else $error("search tag without any search lane");

endmodule

`default_nettype wire

//--- source/lane_decode.sv
// Segment crossbar decode stage
// Splits a request into per-block lane commands (partition, select, spread)
// and builds the search tag for the result stage
`timescale 1ns/1ns
`default_nettype none

`include "xbar_consts.svh"

module lane_decode (
    input  xbar_pkg::xbar_req_t                    req,
    input  logic                                   req_fire,
    input  xbar_pkg::lmt_cfg_t [`XB_NUM_LMTS-1:0]  cfg,
    output xbar_pkg::lane_cmd_t [`XB_NUM_PMTS-1:0] lanes,
    output xbar_pkg::srch_tag_t                    tag
);

    localparam int ID_W   = `XB_PMT_ID_W;
    localparam int SPAN_W = `XB_PMT_ID_W + 2;

    xbar_pkg::lmt_cfg_t      sel;
    logic [SPAN_W-1:0]       span_end;
    logic [`XB_NUM_PMTS-1:0] member;

    assign sel      = cfg[req.lmt];
    assign span_end = {2'b00, sel.first_pmt} + {1'b0, sel.pmt_count};

    // Blocks first_pmt .. first_pmt+count-1 belong to the table
    always_comb begin
        for (int b = 0; b < `XB_NUM_PMTS; b++) begin
            member[b] = (SPAN_W'(b) >= {2'b00, sel.first_pmt}) && (SPAN_W'(b) < span_end);
        end
    end

    always_comb begin
        logic [ID_W-1:0]      rel;
        logic                 col;
        logic [`XB_ROW_W-1:0] row;
        for (int b = 0; b < `XB_NUM_PMTS; b++) begin
            rel = ID_W'(b) - sel.first_pmt;
            // Two-wide tables interleave columns, so bit 0 is the column
            col = sel.width_gear & rel[0];
            row = sel.width_gear ? rel[`XB_ROW_W:1] : rel[`XB_ROW_W-1:0];
            lanes[b] = '0;
            if (req_fire && member[b]) begin
                if (req.op == xbar_pkg::REQ_WRITE) begin
                    // Only the row that holds the address takes the write
                    lanes[b].wr_en = (row == req.addr[`XB_LMT_ADDR_W-1:`XB_PMT_ADDR_W]);
                    lanes[b].addr  = req.addr[`XB_PMT_ADDR_W-1:0];
                    lanes[b].data  = req.payload.wr.data[col*`XB_PMT_WIDTH +: `XB_PMT_WIDTH];
                    lanes[b].care  = req.payload.wr.care[col*`XB_PMT_WIDTH +: `XB_PMT_WIDTH];
                end else begin
                    lanes[b].srch_en = 1'b1;
                    lanes[b].data    = req.payload.srch.key[col*`XB_PMT_WIDTH +: `XB_PMT_WIDTH];
                    lanes[b].care    = '1;
                end
            end
        end
    end

    always_comb begin
        tag            = '0;
        tag.valid      = req_fire && (req.op == xbar_pkg::REQ_SEARCH);
        tag.lmt        = req.lmt;
        tag.first_pmt  = sel.first_pmt;
        tag.width_gear = sel.width_gear;
        tag.depth_gear = sel.depth_gear;
        tag.member     = member;
    end

    // Table must lie inside the pool and match its gears
    always_comb begin
        if (req_fire) begin
            cfg_fits: assert final (span_end <= SPAN_W'(`XB_NUM_PMTS) &&
                {1'b0, sel.pmt_count} == (SPAN_W'(1) << (sel.width_gear + sel.depth_gear)))
            else $error("table %0d does not fit the block pool", req.lmt);
        end
    end

endmodule

`default_nettype wire

//--- source/tcam_block.sv
// Physical ternary match block
// Eight entries of value, care mask and valid bit; writes on wr_en and
// registers one matchline bit per entry on srch_en
`timescale 1ns/1ns
`default_nettype none

`include "xbar_consts.svh"

module tcam_block (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      advance,
    input  xbar_pkg::lane_cmd_t       cmd,
    output logic [`XB_PMT_DEPTH-1:0]  matchline
);

    logic [`XB_PMT_WIDTH-1:0] value_q [`XB_PMT_DEPTH];
    logic [`XB_PMT_WIDTH-1:0] care_q  [`XB_PMT_DEPTH];
    logic [`XB_PMT_DEPTH-1:0] valid_q;
    logic [`XB_PMT_DEPTH-1:0] hit;
    logic [`XB_PMT_DEPTH-1:0] ml_q;
    logic                     wr_take;

    // Command is consumed once, on the edge where the pipeline moves
    assign wr_take = cmd.wr_en && advance;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (wr_take) begin
            valid_q[cmd.addr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take) begin
            value_q[cmd.addr] <= cmd.data;
            care_q[cmd.addr]  <= cmd.care;
        end
    end

    // Entry hits when every cared bit equals the key
    always_comb begin
        for (int e = 0; e < `XB_PMT_DEPTH; e++) begin
            hit[e] = valid_q[e] && (((value_q[e] ^ cmd.data) & care_q[e]) == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            ml_q <= cmd.srch_en ? hit : '0;
        end
    end

    assign matchline = ml_q;

endmodule

`default_nettype wire

//--- source/xbar_pkg.sv
// Segment crossbar shared types
// Table configuration, request and response words, lane commands and search tag
`default_nettype none

`include "xbar_consts.svh"

package xbar_pkg;

    // One logical table, set up statically
    typedef struct packed {
        logic [`XB_PMT_ID_W-1:0]  first_pmt;
        logic [`XB_PMT_CNT_W-1:0] pmt_count;
        logic                     width_gear;
        logic [1:0]               depth_gear;
    } lmt_cfg_t;

    typedef enum logic {
        REQ_WRITE  = 1'b0,
        REQ_SEARCH = 1'b1
    } req_op_t;

    // Care bit set means the data bit takes part in the compare
    typedef struct packed {
        logic [`XB_LMT_WIDTH-1:0] data;
        logic [`XB_LMT_WIDTH-1:0] care;
    } wr_view_t;

    typedef struct packed {
        logic [`XB_LMT_WIDTH-1:0] key;
        logic [`XB_LMT_WIDTH-1:0] reserved;
    } srch_view_t;

    // Same 64 bits, read as write data or as search key by op
    typedef union packed {
        wr_view_t   wr;
        srch_view_t srch;
    } req_payload_u;

    typedef struct packed {
        req_op_t                          op;
        logic [$clog2(`XB_NUM_LMTS)-1:0]  lmt;
        logic [`XB_LMT_ADDR_W-1:0]        addr;
        req_payload_u                     payload;
    } xbar_req_t;

    // Command for one physical block
    typedef struct packed {
        logic                      wr_en;
        logic                      srch_en;
        logic [`XB_PMT_ADDR_W-1:0] addr;
        logic [`XB_PMT_WIDTH-1:0]  data;
        logic [`XB_PMT_WIDTH-1:0]  care;
    } lane_cmd_t;

    // Travels beside the lanes so the result stage knows the table shape
    typedef struct packed {
        logic                             valid;
        logic [$clog2(`XB_NUM_LMTS)-1:0]  lmt;
        logic [`XB_PMT_ID_W-1:0]          first_pmt;
        logic                             width_gear;
        logic [1:0]                       depth_gear;
        logic [`XB_NUM_PMTS-1:0]          member;
    } srch_tag_t;

    typedef struct packed {
        logic [$clog2(`XB_NUM_LMTS)-1:0]  lmt;
        logic                             found;
        logic [`XB_LMT_ADDR_W-1:0]        match_addr;
        logic [`XB_LMT_DEPTH-1:0]         matchlines;
    } xbar_resp_t;

endpackage

`default_nettype wire

//--- source/xbar_consts.svh
// Segment crossbar sizing constants
// Physical TCAM block geometry, logical table limits and index widths
`ifndef XBAR_CONSTS_SVH
`define XBAR_CONSTS_SVH

// ========================================
// Physical blocks
// ========================================
`define XB_NUM_PMTS     8
`define XB_PMT_WIDTH    16
`define XB_PMT_DEPTH    8
`define XB_PMT_ADDR_W   3
`define XB_PMT_ID_W     3
// Block count of one table, 0 to 8
`define XB_PMT_CNT_W    4

// ========================================
// Logical tables
// ========================================
`define XB_NUM_LMTS     2
`define XB_LMT_WIDTH    32
`define XB_LMT_DEPTH    32
`define XB_LMT_ADDR_W   5

// Depth rows of the deepest table and the row index width
`define XB_MAX_ROWS     4
`define XB_ROW_W        2

`endif
